/* avr_core.f */
source/avr_core_pkg.sv
source/avr_isa_pkg.sv
source/avr_decode.sv
source/avr_regs.sv
source/avr_alu.sv
source/avr_pc.sv
source/avr_core.sv
test/tb_clock.sv
test/avr_core_assert.sv
test/avr_core_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it and scan the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f avr_core.f --top-module avr_core_tb -o avr_core_sim
./obj_dir/avr_core_sim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi
grep -q "Everything OK" sim.log

/* source/avr_alu.sv */
// ALU with AVR flag rules and the status register
// Result source select and the I/O read/write strobes

`timescale 1ns/100ps

module avr_alu import avr_core_pkg::*, avr_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  decoded_t dec,
	input  data_t    rd_data,
	input  data_t    rr_data,
	input  data_t    io_in,
	output data_t    result,
	output sreg_t    sreg,
	output logic     io_we,
	output logic     io_re
);

	data_t a;
	data_t b;
	data_t res;
	logic cin;
	logic [8:0] sum;
	logic [8:0] diff;
	sreg_t sreg_next;

	assign a = rd_data;
	assign b = dec.use_imm ? dec.imm : rr_data;

	// Carry in only for ADC, SBC and CPC
	assign cin = (dec.alu_op == alu_adc || dec.alu_op == alu_sbc) && sreg.c;
	assign sum = {1'b0, a} + {1'b0, b} + 9'(cin);
	assign diff = {1'b0, a} - {1'b0, b} - 9'(cin);  // Bit 8 is the borrow

	always_comb
	begin
		sreg_next = sreg;
		res = b;  // Pass for MOV and LDI
		case (dec.alu_op)
			alu_add, alu_adc:
			begin
				res = sum[7:0];
				sreg_next.c = sum[8];
				sreg_next.h = (a[3] & b[3]) | (b[3] & ~res[3]) | (~res[3] & a[3]);
				sreg_next.v = (a[7] & b[7] & ~res[7]) | (~a[7] & ~b[7] & res[7]);
			end
			alu_sub, alu_sbc:
			begin
				res = diff[7:0];
				sreg_next.c = diff[8];
				sreg_next.h = (~a[3] & b[3]) | (b[3] & res[3]) | (res[3] & ~a[3]);
				sreg_next.v = (a[7] & ~b[7] & ~res[7]) | (~a[7] & b[7] & res[7]);
			end
			alu_and: res = a & b;
			alu_or:  res = a | b;
			alu_eor: res = a ^ b;
			default: res = b;
		endcase
		if (dec.alu_op inside {alu_and, alu_or, alu_eor})
			sreg_next.v = 1'b0;
		// SBC and CPC can only keep Z, never set it
		sreg_next.z = (res == '0) && (dec.alu_op != alu_sbc || sreg.z);
		sreg_next.n = res[7];
		sreg_next.s = sreg_next.n ^ sreg_next.v;
		sreg_next.i = 1'b0;
		sreg_next.t = 1'b0;
	end

	always_comb
	begin
		if (dec.op == op_in)
			result = (dec.io_addr == sreg_io_addr) ? data_t'(sreg) : io_in;
		else
			result = res;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			sreg <= sreg_reset;
		else if (dec.flag_we)
			sreg <= sreg_next;
	end

	// Status register reads stay inside the core
	assign io_we = !rst && dec.op == op_out;
	assign io_re = !rst && dec.op == op_in && dec.io_addr != sreg_io_addr;

endmodule

/* source/avr_core.sv */
// Top level of the single-cycle core
// Decode, register file, ALU and program counter

`timescale 1ns/100ps

module avr_core import avr_core_pkg::*, avr_isa_pkg::*;
#(
	parameter int pc_width = 11
)
(
	input  logic                clk,
	input  logic                rst,
	output logic [pc_width-1:0] pgm_addr,
	input  insn_t               pgm_data,
	output io_addr_t            io_addr,
	output data_t               io_out,
	output logic                io_we,
	input  data_t               io_in,
	output logic                io_re
);

	decoded_t dec;
	data_t rd_data;
	data_t rr_data;
	data_t result;
	sreg_t sreg;

	avr_decode decode_i (
		.insn(pgm_data),
		.dec (dec)
	);

	avr_regs regs_i (
		.clk    (clk),
		.dec    (dec),
		.wdata  (result),
		.rd_data(rd_data),
		.rr_data(rr_data)
	);

	avr_alu alu_i (
		.clk    (clk),
		.rst    (rst),
		.dec    (dec),
		.rd_data(rd_data),
		.rr_data(rr_data),
		.io_in  (io_in),
		.result (result),
		.sreg   (sreg),
		.io_we  (io_we),
		.io_re  (io_re)
	);

	avr_pc #(.pc_width(pc_width)) pc_i (
		.clk (clk),
		.rst (rst),
		.dec (dec),
		.sreg(sreg),
		.pc  (pgm_addr)
	);

	assign io_addr = dec.io_addr;
	assign io_out = rd_data;  // OUT source register sits in the rd field

endmodule

/* source/avr_core_pkg.sv */
// Datapath widths of the core
// Status register layout and its reset value

package avr_core_pkg;

	typedef logic [7:0] data_t;      // Register and I/O byte
	typedef logic [4:0] reg_addr_t;  // Register file index
	typedef logic [5:0] io_addr_t;   // I/O space address
	typedef logic [15:0] insn_t;     // Program word

	// Status register, bit 7 down to bit 0
	typedef struct packed {
		logic i;  // Reads 0, interrupts not present
		logic t;  // Reads 0, BLD/BST not present
		logic h;  // Half carry
		logic s;  // Sign, n ^ v
		logic v;  // Two's complement overflow
		logic n;  // Negative
		logic z;  // Zero
		logic c;  // Carry or borrow
	} sreg_t;

	// IN from this address returns the status register
	localparam io_addr_t sreg_io_addr = 6'h3f;

	localparam sreg_t sreg_reset = '0;

endpackage

/* source/avr_decode.sv */
// Instruction decoder
// Maps a program word onto the decoded_t control struct

`timescale 1ns/100ps

module avr_decode import avr_core_pkg::*, avr_isa_pkg::*;
(
	input  insn_t    insn,
	output decoded_t dec
);

	op_e op;

	always_comb
	begin
		if (insn[15:12] == opc_ldi) op = op_ldi;
		else if (insn[15:12] == opc_subi) op = op_subi;
		else if (insn[15:12] == opc_andi) op = op_andi;
		else if (insn[15:12] == opc_ori) op = op_ori;
		else if (insn[15:12] == opc_rjmp) op = op_rjmp;
		else if (insn[15:11] == opc_in) op = op_in;
		else if (insn[15:11] == opc_out) op = op_out;
		else if (insn[15:10] == opc_add) op = op_add;
		else if (insn[15:10] == opc_adc) op = op_adc;
		else if (insn[15:10] == opc_sub) op = op_sub;
		else if (insn[15:10] == opc_sbc) op = op_sbc;
		else if (insn[15:10] == opc_and) op = op_and;
		else if (insn[15:10] == opc_or) op = op_or;
		else if (insn[15:10] == opc_eor) op = op_eor;
		else if (insn[15:10] == opc_mov) op = op_mov;
		else if (insn[15:10] == opc_cp) op = op_cp;
		else if (insn[15:10] == opc_cpc) op = op_cpc;
		else if (insn[15:10] == opc_brbs) op = op_brbs;
		else if (insn[15:10] == opc_brbc) op = op_brbc;
		else op = op_nop;  // Unkept words just advance the PC
	end

	always_comb
	begin
		dec.op = op;
		case (op)
			op_add:                 dec.alu_op = alu_add;
			op_adc:                 dec.alu_op = alu_adc;
			op_sub, op_subi, op_cp: dec.alu_op = alu_sub;
			op_sbc, op_cpc:         dec.alu_op = alu_sbc;
			op_and, op_andi:        dec.alu_op = alu_and;
			op_or, op_ori:          dec.alu_op = alu_or;
			op_eor:                 dec.alu_op = alu_eor;
			default:                dec.alu_op = alu_pass;  // MOV and LDI
		endcase

		dec.use_imm = op inside {op_ldi, op_subi, op_andi, op_ori};
		dec.reg_we = op inside {op_ldi, op_add, op_adc, op_sub, op_sbc, op_and, op_or,
			op_eor, op_mov, op_subi, op_andi, op_ori, op_in};
		dec.flag_we = op inside {op_add, op_adc, op_sub, op_sbc, op_and, op_or, op_eor,
			op_cp, op_cpc, op_subi, op_andi, op_ori};

		// Immediate forms only reach r16..r31
		dec.rd = dec.use_imm ? {1'b1, insn[7:4]} : insn[8:4];
		dec.rr = {insn[9], insn[3:0]};
		dec.imm = {insn[11:8], insn[3:0]};
		dec.io_addr = {insn[10:9], insn[3:0]};

		if (op == op_rjmp)
			dec.rel_offset = insn[11:0];
		else
			dec.rel_offset = {{5{insn[9]}}, insn[9:3]};  // 7-bit branch offset
		dec.branch_bit = insn[2:0];
		dec.branch_if_set = (op == op_brbs);
	end

endmodule

/* source/avr_isa_pkg.sv */
// Operation and ALU function enums
// Decoded instruction struct and opcode patterns of the kept instructions

package avr_isa_pkg;
	import avr_core_pkg::*;

	typedef enum logic [4:0] {
		op_nop, op_ldi, op_add, op_adc, op_sub, op_sbc, op_and, op_or, op_eor,
		op_mov, op_cp, op_cpc, op_subi, op_andi, op_ori, op_in, op_out,
		op_rjmp, op_brbs, op_brbc
	} op_e;

	typedef enum logic [2:0] {
		alu_add, alu_adc, alu_sub, alu_sbc, alu_and, alu_or, alu_eor, alu_pass
	} alu_op_e;

	typedef logic signed [11:0] rel_off_t;  // Word offset

	typedef struct packed {
		op_e       op;
		alu_op_e   alu_op;
		reg_addr_t rd;
		reg_addr_t rr;
		data_t     imm;
		logic      use_imm;        // Second operand is imm
		logic      reg_we;
		logic      flag_we;
		io_addr_t  io_addr;
		rel_off_t  rel_offset;
		logic [2:0] branch_bit;    // Status bit tested
		logic      branch_if_set;
	} decoded_t;

	// Two-register forms, matched on insn[15:10]
	localparam logic [5:0] opc_add  = 6'b000011;
	localparam logic [5:0] opc_adc  = 6'b000111;
	localparam logic [5:0] opc_sub  = 6'b000110;
	localparam logic [5:0] opc_sbc  = 6'b000010;
	localparam logic [5:0] opc_and  = 6'b001000;
	localparam logic [5:0] opc_eor  = 6'b001001;
	localparam logic [5:0] opc_or   = 6'b001010;
	localparam logic [5:0] opc_mov  = 6'b001011;
	localparam logic [5:0] opc_cp   = 6'b000101;
	localparam logic [5:0] opc_cpc  = 6'b000001;
	// Branches, also insn[15:10]
	localparam logic [5:0] opc_brbs = 6'b111100;
	localparam logic [5:0] opc_brbc = 6'b111101;
	// Immediate forms and RJMP on insn[15:12]
	localparam logic [3:0] opc_ldi  = 4'b1110;
	localparam logic [3:0] opc_subi = 4'b0101;
	localparam logic [3:0] opc_andi = 4'b0111;
	localparam logic [3:0] opc_ori  = 4'b0110;
	localparam logic [3:0] opc_rjmp = 4'b1100;
	// I/O on insn[15:11]
	localparam logic [4:0] opc_in   = 5'b10110;
	localparam logic [4:0] opc_out  = 5'b10111;

endpackage

/* source/avr_pc.sv */
// Program counter
// Increment, RJMP and conditional branch on one status bit

`timescale 1ns/100ps

module avr_pc import avr_core_pkg::*, avr_isa_pkg::*;
#(
	parameter int pc_width = 11
)
(
	input  logic                clk,
	input  logic                rst,
	input  decoded_t            dec,
	input  sreg_t               sreg,
	output logic [pc_width-1:0] pc
);

	logic [pc_width-1:0] pc_inc;
	logic [pc_width-1:0] target;
	data_t flags;
	logic taken;

	assign pc_inc = pc + pc_width'(1);
	assign target = pc_inc + pc_width'($signed(dec.rel_offset));  // Wraps mod 2**pc_width

	assign flags = sreg;  // Bits 6 and 7 are always 0
	assign taken = (dec.op == op_brbs || dec.op == op_brbc)
		&& flags[dec.branch_bit] == dec.branch_if_set;

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (dec.op == op_rjmp || taken)
			pc <= target;
		else
			pc <= pc_inc;
	end

endmodule

/* source/avr_regs.sv */
// General purpose register file, r0..r31
// Two asynchronous read ports, one synchronous write port

`timescale 1ns/100ps

module avr_regs import avr_core_pkg::*, avr_isa_pkg::*;
(
	input  logic     clk,
	input  decoded_t dec,
	input  data_t    wdata,
	output data_t    rd_data,
	output data_t    rr_data
);

	data_t regs [32];

	always_ff @(posedge clk)
	begin
		if (dec.reg_we)
			regs[dec.rd] <= wdata;
	end

	// Reads see the old value during a write cycle
	assign rd_data = regs[dec.rd];
	assign rr_data = regs[dec.rr];

endmodule

/* test/avr_core_assert.sv */
// Concurrent checks on the I/O strobes and the reset state of the core
// Bound into every avr_core instance

`timescale 1ns/100ps

module avr_core_assert #(
	parameter int pc_width = 11
)
(
	input logic                clk,
	input logic                rst,
	input logic [pc_width-1:0] pgm_addr,
	input logic                io_we,
	input logic                io_re
);

	strobes_exclusive: assert property (@(posedge clk) !(io_we && io_re))
		else $error("io_we and io_re high in the same cycle");

	strobes_off_in_reset: assert property (@(posedge clk) rst |-> !io_we && !io_re)
		else $error("I/O strobe high while rst is asserted");

	// First fetch after reset comes from address 0
	pc_zero_after_reset: assert property (@(posedge clk) $fell(rst) |-> pgm_addr == '0)
		else $error("pgm_addr not 0 in the cycle after reset");

endmodule

bind avr_core avr_core_assert #(.pc_width(pc_width)) assert_i (
	.clk     (clk),
	.rst     (rst),
	.pgm_addr(pgm_addr),
	.io_we   (io_we),
	.io_re   (io_re)
);

/* test/avr_core_tb.sv */
// Testbench of the core: program ROM model and I/O write/read monitor
// Directed tests for fetch, arithmetic, logic, I/O read and control flow

`timescale 1ns/100ps

module avr_core_tb import avr_core_pkg::*;
();

	localparam int pc_width = 11;
	localparam int test_budget = 400;  // Cycles per test, each needs far fewer
	localparam int watchdog_cycles = 5 * test_budget;
	// ADD ADC SUB SBC (SUBI slot) CP CPC
	localparam logic [5:0] arith_opc [7] = '{6'b000011, 6'b000111, 6'b000110, 6'b000010,
		6'b000000, 6'b000101, 6'b000001};
	localparam logic [5:0] logic_opc [4] = '{6'b001000, 6'b001010, 6'b001001, 6'b001011};
	localparam int flow_trace [15] = '{0, 1, 2, 3, 6, 8, 9, 10, 11, 12, 15, 18, 16, 17, 21};

	logic clk;
	logic por_rst;
	logic rst_req = 1'b0;
	logic [pc_width-1:0] pgm_addr;
	insn_t pgm_data = '0;
	io_addr_t io_addr;
	data_t io_out;
	data_t io_in = '0;
	data_t io_in_val = '0;
	logic io_we;
	logic io_re;
	insn_t rom [2**pc_width];
	logic [13:0] wr_log [$];  // {io_addr, io_out} per write
	io_addr_t re_log [$];
	logic [pc_width-1:0] pc_trace [$];
	logic [31:0] rng = 32'h5af4_899b;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock #(.period(10), .reset_cycles(5)) clock_i (.clk(clk), .rst(por_rst));

	avr_core #(.pc_width(pc_width)) dut_i (
		.clk     (clk),
		.rst     (por_rst | rst_req),
		.pgm_addr(pgm_addr),
		.pgm_data(pgm_data),
		.io_addr (io_addr),
		.io_out  (io_out),
		.io_we   (io_we),
		.io_in   (io_in),
		.io_re   (io_re)
	);

	always @(negedge clk)
	begin
		pgm_data <= rom[pgm_addr];  // Asynchronous ROM answer
		io_in <= io_in_val;
	end

	always @(posedge clk)
	begin
		if (io_we)
			wr_log.push_back({io_addr, io_out});
		if (io_re)
			re_log.push_back(io_addr);
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("Something failed");
		$finish;
	end

	function automatic logic [7:0] rand8();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng[7:0];
	endfunction

	function automatic insn_t reg_op(input logic [5:0] opc, input int rd, input int rr);
		return {opc, rr[4], rd[4:0], rr[3:0]};
	endfunction

	function automatic insn_t imm_op(input logic [3:0] opc, input int rd, input logic [7:0] k);
		return {opc, k[7:4], rd[3:0], k[3:0]};  // rd is r16..r31
	endfunction

	function automatic insn_t io_op(input logic is_out, input int a, input int r);
		return {4'b1011, is_out, a[5:4], r[4:0], a[3:0]};
	endfunction

	// Expected {result, status} of an add or subtract
	function automatic logic [15:0] arith_model(input logic [7:0] a, input logic [7:0] b,
		input logic sub, input logic use_c, input logic keep_z, input logic [7:0] s_in);
		logic ci;
		logic [8:0] full;
		logic [4:0] half;
		logic [7:0] r;
		logic v;
		logic z;
		ci = use_c & s_in[0];
		if (sub)
		begin
			full = {1'b0, a} - {1'b0, b} - 9'(ci);
			half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(ci);  // Borrow from bit 3
		end
		else
		begin
			full = {1'b0, a} + {1'b0, b} + 9'(ci);
			half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(ci);
		end
		r = full[7:0];
		v = (r[7] != a[7]) && ((a[7] == b[7]) != sub);
		z = (r == 8'h00) && (!keep_z || s_in[1]);
		return {r, 2'b00, half[4], r[7] ^ v, v, r[7], z, full[8]};
	endfunction

	task automatic fill_rom();
		for (int i = 0; i < 2**pc_width; i++)
			rom[i] = {5'b10010, 11'(i)};  // Unkept opcode space, runs as no-op
	endtask

	task automatic run_prog(input int cycles);
		@(negedge clk);
		rst_req = 1'b1;
		repeat (5)
		begin
			@(negedge clk);
			if (io_we || io_re)
			begin
				$display("I/O strobe was high while rst was asserted");
				errors++;
			end
		end
		wr_log.delete();
		re_log.delete();
		pc_trace.delete();
		rst_req = 1'b0;
		for (int i = 0; i < cycles; i++)
		begin
			pc_trace.push_back(pgm_addr);
			@(negedge clk);
		end
	endtask

	// LDI both operands, run op, save status, then OUT result and status
	task automatic put_block(input int k, input logic [7:0] a, input logic [7:0] b,
		input insn_t op_word);
		rom[6*k] = imm_op(4'b1110, 16, a);
		rom[6*k+1] = imm_op(4'b1110, 17, b);
		rom[6*k+2] = op_word;
		rom[6*k+3] = io_op(1'b0, 'h3f, 18);
		rom[6*k+4] = io_op(1'b1, 2*k, 16);
		rom[6*k+5] = io_op(1'b1, 2*k+1, 18);
	endtask

	task automatic expect_write(input int idx, input io_addr_t addr, input data_t data);
		if (wr_log[idx] !== {addr, data})
		begin
			$display("Fail io_addr,io_out: got %h,%h expected %h,%h",
				wr_log[idx][13:8], wr_log[idx][7:0], addr, data);
			errors++;
		end
	endtask

	task automatic check_counts(input int n_wr, input int n_re);
		if (wr_log.size() != n_wr || re_log.size() != n_re)
		begin
			$display("Expected %0d I/O writes and %0d reads but saw %0d and %0d",
				n_wr, n_re, wr_log.size(), re_log.size());
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		if (errors != start)
			tests_failed++;
		$display("%s test %s", name, (errors == start) ? "passed" : "failed");
	endtask

	task automatic test_fetch();
		int start = errors;
		fill_rom();
		rom[0] = io_op(1'b1, 'h10, 0);  // Presented during reset, runs once after
		run_prog(8);
		check_counts(1, 0);
		if (wr_log[0][13:8] !== 6'h10)
		begin
			$display("Fail io_addr: got %h, expected 10", wr_log[0][13:8]);
			errors++;
		end
		for (int i = 0; i < 8; i++)
			if (pc_trace[i] !== pc_width'(i))
			begin
				$display("Fail pgm_addr: got %h, expected %h", pc_trace[i], pc_width'(i));
				errors++;
			end
		report_test("fetch", start);
	endtask

	task automatic test_arith();
		int start = errors;
		logic [7:0] a [7];
		logic [7:0] b [7];
		logic [7:0] s;
		logic [15:0] m;
		fill_rom();
		for (int k = 0; k < 7; k++)
		begin
			a[k] = rand8();
			// CP borrows and clears Z, so CPC reaches zero with Z clear
			b[k] = (k == 5) ? a[k] + 8'd1 : (k == 6) ? a[k] - 8'd1 : rand8();
			put_block(k, a[k], b[k], (k == 4) ? imm_op(4'b0101, 16, b[k]) :
				reg_op(arith_opc[k], 16, 17));
		end
		run_prog(44);
		check_counts(14, 0);  // IN from 0x3F leaves io_re low
		s = 8'h00;
		for (int k = 0; k < 7; k++)
		begin
			m = arith_model(a[k], b[k], k >= 2, k == 1 || k == 3 || k == 6, k == 3 || k == 6, s);
			s = m[7:0];
			expect_write(2*k, 6'(2*k), (k >= 5) ? a[k] : m[15:8]);  // CP/CPC keep rd
			expect_write(2*k+1, 6'(2*k+1), s);
		end
		report_test("arithmetic", start);
	endtask

	task automatic test_logic();
		int start = errors;
		logic [7:0] a [6];
		logic [7:0] b [6];
		logic [7:0] r;
		logic [7:0] s;
		fill_rom();
		for (int k = 0; k < 6; k++)
		begin
			a[k] = rand8();
			b[k] = rand8();
			put_block(k, a[k], b[k], (k < 4) ? reg_op(logic_opc[k], 16, 17) :
				imm_op((k == 4) ? 4'b0111 : 4'b0110, 16, b[k]));
		end
		run_prog(38);
		check_counts(12, 0);
		s = 8'h00;
		for (int k = 0; k < 6; k++)
		begin
			case (k)
				0, 4: r = a[k] & b[k];
				1, 5: r = a[k] | b[k];
				2: r = a[k] ^ b[k];
				default: r = b[k];  // MOV
			endcase
			if (k != 3)
				s = {2'b00, s[5], r[7], 1'b0, r[7], r == 8'h00, s[0]};  // V cleared, S = N
			expect_write(2*k, 6'(2*k), r);
			expect_write(2*k+1, 6'(2*k+1), s);
		end
		report_test("logic", start);
	endtask

	task automatic test_io_read();
		int start = errors;
		fill_rom();
		io_in_val = rand8();
		rom[0] = io_op(1'b0, 'h15, 20);
		rom[1] = io_op(1'b1, 'h22, 20);
		run_prog(4);
		check_counts(1, 1);
		if (re_log[0] !== 6'h15)
		begin
			$display("Fail io_addr on read: got %h, expected 15", re_log[0]);
			errors++;
		end
		expect_write(0, 6'h22, io_in_val);
		report_test("io_read", start);
	endtask

	task automatic test_flow();
		int start = errors;
		fill_rom();
		rom[0] = imm_op(4'b1110, 16, 8'd7);
		rom[1] = imm_op(4'b1110, 17, 8'd7);
		rom[2] = reg_op(6'b000101, 16, 17);  // CP sets Z
		rom[3] = {4'b1100, 12'd2};  // RJMP to 6
		rom[4] = io_op(1'b1, 'h31, 16);
		rom[5] = io_op(1'b1, 'h32, 16);
		rom[6] = {6'b111100, 7'd1, 3'd1};  // BRBS Z to 8
		rom[7] = io_op(1'b1, 'h33, 16);
		rom[8] = {6'b111101, 7'd3, 3'd1};  // BRBC Z falls through
		rom[9] = io_op(1'b1, 'h34, 16);
		rom[10] = {6'b111100, 7'd1, 3'd6};  // Bit 6 reads 0
		rom[11] = io_op(1'b1, 'h35, 16);
		rom[12] = {6'b111101, 7'd2, 3'd6};  // BRBC bit 6 to 15
		rom[13] = io_op(1'b1, 'h36, 16);
		rom[14] = io_op(1'b1, 'h37, 16);
		rom[15] = {4'b1100, 12'd2};  // RJMP to 18
		rom[16] = io_op(1'b1, 'h38, 16);
		rom[17] = {4'b1100, 12'd3};  // RJMP to 21
		rom[18] = {4'b1100, 12'hffd};  // RJMP back to 16
		run_prog(15);
		check_counts(3, 0);
		expect_write(0, 6'h34, 8'd7);
		expect_write(1, 6'h35, 8'd7);
		expect_write(2, 6'h38, 8'd7);
		for (int i = 0; i < 15; i++)
			if (pc_trace[i] !== pc_width'(flow_trace[i]))
			begin
				$display("Fail pgm_addr: got %h, expected %h", pc_trace[i],
					pc_width'(flow_trace[i]));
				errors++;
			end
		report_test("control_flow", start);
	endtask

	initial
	begin
		test_fetch();
		test_arith();
		test_logic();
		test_io_read();
		test_flow();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* test/tb_clock.sv */
// Clock and power-on reset for the testbench

`timescale 1ns/100ps

module tb_clock #(
	parameter int period = 10,
	parameter int reset_cycles = 5
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk) rst = 1'b0;  // Release away from the active edge
	end

endmodule
